//--- verilog/cce_msg_pkg.sv
// Message unit shared definitions
package cce_msg_pkg;

  // sizes
  localparam int num_lce = 4;
  localparam int lce_id_width = 2;
  localparam int way_width = 3;
  localparam int paddr_width = 16;
  localparam int block_width = 64;
  localparam int coh_state_width = 3;
  localparam int mem_msg_width = 2;
  localparam int lce_cmd_width = 2;
  localparam int lce_resp_width = 1;
  // count of outstanding invalidates, 0 to num_lce
  localparam int inv_cnt_width = 3;

  // vector types
  typedef logic [paddr_width-1:0] paddr_t;
  typedef logic [lce_id_width-1:0] lce_id_t;
  typedef logic [way_width-1:0] way_id_t;
  typedef logic [block_width-1:0] block_data_t;
  typedef logic [num_lce-1:0] sharers_t;
  // way of each LCE, LCE 0 in the low bits
  typedef logic [num_lce*way_width-1:0] sharer_ways_t;
  typedef logic [coh_state_width-1:0] coh_state_t;
  typedef logic [mem_msg_width-1:0] mem_msg_t;
  typedef logic [lce_cmd_width-1:0] lce_cmd_t;
  typedef logic [lce_resp_width-1:0] lce_resp_t;
  typedef logic [inv_cnt_width-1:0] inv_cnt_t;

  // engine id, source of every command
  localparam lce_id_t cce_id = lce_id_t'(0);

  // coherence states
  localparam coh_state_t coh_i = coh_state_t'(0);

  // memory message codes
  localparam mem_msg_t mem_rd = mem_msg_t'(0);
  localparam mem_msg_t mem_wr = mem_msg_t'(1);
  localparam mem_msg_t mem_uc_rd = mem_msg_t'(2);
  localparam mem_msg_t mem_uc_wr = mem_msg_t'(3);

  // LCE command codes
  localparam lce_cmd_t cmd_data = lce_cmd_t'(0);
  localparam lce_cmd_t cmd_uc_data = lce_cmd_t'(1);
  localparam lce_cmd_t cmd_uc_st_done = lce_cmd_t'(2);
  localparam lce_cmd_t cmd_inv = lce_cmd_t'(3);

  // LCE response codes
  localparam lce_resp_t resp_coh_ack = lce_resp_t'(0);
  localparam lce_resp_t resp_inv_ack = lce_resp_t'(1);

  // saturation point of the ack counter
  localparam inv_cnt_t inv_cnt_max = inv_cnt_t'(num_lce);

  // control states
  typedef enum logic [1:0] {
    st_reset,
    st_ready,
    st_inv_cmd,
    st_inv_resp
  } msg_state_e;

endpackage

//--- verilog/mem_resp_fwd.sv
// Memory response decode
`timescale 1ns/100ps

module mem_resp_fwd (
  input  logic                     mem_resp_v_i,
  input  cce_msg_pkg::mem_msg_t    mem_resp_type_i,
  input  cce_msg_pkg::paddr_t      mem_resp_addr_i,
  input  cce_msg_pkg::lce_id_t     mem_resp_lce_i,
  input  cce_msg_pkg::way_id_t     mem_resp_way_i,
  input  cce_msg_pkg::coh_state_t  mem_resp_state_i,
  input  cce_msg_pkg::block_data_t mem_resp_data_i,
  output logic                     fwd_cmd_v_o,
  output logic                     fwd_pend_v_o,
  output cce_msg_pkg::lce_cmd_t    fwd_type_o,
  output cce_msg_pkg::lce_id_t     fwd_dst_o,
  output cce_msg_pkg::paddr_t      fwd_addr_o,
  output cce_msg_pkg::way_id_t     fwd_way_o,
  output cce_msg_pkg::coh_state_t  fwd_state_o,
  output cce_msg_pkg::block_data_t fwd_data_o
);

  logic needs_cmd;
  logic needs_pend;

  // header fields pass straight through
  assign fwd_dst_o = mem_resp_lce_i;
  assign fwd_addr_o = mem_resp_addr_i;
  assign fwd_way_o = mem_resp_way_i;

  always_comb begin
    needs_cmd = 1'b0;
    needs_pend = 1'b0;
    fwd_type_o = cce_msg_pkg::cmd_data;
    fwd_state_o = mem_resp_state_i;
    fwd_data_o = mem_resp_data_i;
    case (mem_resp_type_i)
      cce_msg_pkg::mem_rd: begin
        // cached fill, also retires the pending bit
        needs_cmd = 1'b1;
        needs_pend = 1'b1;
        fwd_type_o = cce_msg_pkg::cmd_data;
      end
      cce_msg_pkg::mem_wr: begin
        // writeback ack, pending clear only
        needs_pend = 1'b1;
      end
      cce_msg_pkg::mem_uc_rd: begin
        needs_cmd = 1'b1;
        fwd_type_o = cce_msg_pkg::cmd_uc_data;
      end
      cce_msg_pkg::mem_uc_wr: begin
        // store done carries no payload
        needs_cmd = 1'b1;
        fwd_type_o = cce_msg_pkg::cmd_uc_st_done;
        fwd_state_o = cce_msg_pkg::coh_i;
        fwd_data_o = '0;
      end
      default: begin
        needs_cmd = 1'b0;
      end
    endcase
  end

  assign fwd_cmd_v_o = mem_resp_v_i & needs_cmd;
  assign fwd_pend_v_o = mem_resp_v_i & needs_pend;

endmodule

//--- verilog/cce_msg_ctrl.sv
// Message unit control
`timescale 1ns/100ps

module cce_msg_ctrl (
  input  logic                   clk_i,
  input  logic                   reset_i,
  input  logic                   inv_start_i,
  input  logic                   fwd_cmd_v_i,
  input  logic                   fwd_pend_v_i,
  input  logic                   mem_resp_v_i,
  input  logic                   lce_resp_v_i,
  input  cce_msg_pkg::lce_resp_t lce_resp_type_i,
  input  logic                   lce_cmd_ready_i,
  input  logic                   last_i,
  input  logic                   cnt_zero_i,
  input  logic                   cnt_one_i,
  output logic                   mem_resp_yumi_o,
  output logic                   lce_resp_yumi_o,
  output logic                   lce_cmd_v_o,
  output logic                   inv_sel_o,
  output logic                   pending_w_v_o,
  output logic                   pend_from_resp_o,
  output logic                   dir_w_v_o,
  output logic                   load_o,
  output logic                   step_o,
  output logic                   cnt_clr_o,
  output logic                   cnt_inc_o,
  output logic                   cnt_dec_o,
  output logic                   busy_o
);

  cce_msg_pkg::msg_state_e state_r, state_n;

  logic active;
  logic in_inv;
  logic fwd_go;
  logic wb_go;
  logic resp_pend;
  logic coh_ack_go;
  logic inv_ack_go;
  logic inv_go;

  // nothing moves while the state sits in st_reset
  assign active = (state_r != cce_msg_pkg::st_reset);
  assign in_inv = (state_r == cce_msg_pkg::st_inv_cmd) | (state_r == cce_msg_pkg::st_inv_resp);

  // forwarded response owns the command port, only when the LCE side is ready
  assign fwd_go = active & fwd_cmd_v_i & lce_cmd_ready_i;
  // writeback response needs no command, taken at once
  assign wb_go = active & mem_resp_v_i & ~fwd_cmd_v_i;
  assign resp_pend = fwd_pend_v_i & (fwd_go | wb_go);

  // coh ack loses the pending port to a memory response
  assign coh_ack_go = active & lce_resp_v_i
                      & (lce_resp_type_i == cce_msg_pkg::resp_coh_ack) & ~resp_pend;
  // inv acks only drained while an invalidation runs
  assign inv_ack_go = in_inv & lce_resp_v_i & (lce_resp_type_i == cce_msg_pkg::resp_inv_ack);

  // invalidate goes out when forwarding leaves the port free
  assign inv_go = (state_r == cce_msg_pkg::st_inv_cmd) & lce_cmd_ready_i & ~fwd_cmd_v_i;

  assign mem_resp_yumi_o = fwd_go | wb_go;
  assign lce_resp_yumi_o = coh_ack_go | inv_ack_go;
  assign lce_cmd_v_o = fwd_go | inv_go;
  assign inv_sel_o = (state_r == cce_msg_pkg::st_inv_cmd) & ~fwd_cmd_v_i;
  assign pending_w_v_o = resp_pend | coh_ack_go;
  assign pend_from_resp_o = resp_pend;
  assign dir_w_v_o = inv_go;
  assign step_o = inv_go;
  assign cnt_inc_o = inv_go;
  assign cnt_dec_o = inv_ack_go;
  assign busy_o = in_inv;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r <= cce_msg_pkg::st_reset;
    end else begin
      state_r <= state_n;
    end
  end

  always_comb begin
    state_n = state_r;
    load_o = 1'b0;
    cnt_clr_o = 1'b0;
    unique case (state_r)
      cce_msg_pkg::st_reset: begin
        state_n = cce_msg_pkg::st_ready;
        cnt_clr_o = 1'b1;
      end
      cce_msg_pkg::st_ready: begin
        // capture sharers and start with a clean count
        if (inv_start_i) begin
          load_o = 1'b1;
          cnt_clr_o = 1'b1;
          state_n = cce_msg_pkg::st_inv_cmd;
        end
      end
      cce_msg_pkg::st_inv_cmd: begin
        if (inv_go && last_i) begin
          state_n = cce_msg_pkg::st_inv_resp;
        end
      end
      cce_msg_pkg::st_inv_resp: begin
        // done once nothing is outstanding, or the last ack is taken now
        if (cnt_zero_i || (inv_ack_go && cnt_one_i)) begin
          state_n = cce_msg_pkg::st_ready;
        end
      end
      default: begin
        state_n = cce_msg_pkg::st_reset;
      end
    endcase
  end

endmodule

//--- verilog/inv_sharer_select.sv
// Invalidation sharer selection
`timescale 1ns/100ps

module inv_sharer_select (
  input  logic                      clk_i,
  input  logic                      reset_i,
  input  logic                      load_i,
  input  logic                      step_i,
  input  cce_msg_pkg::sharers_t     sharers_hits_i,
  input  cce_msg_pkg::sharer_ways_t sharers_ways_i,
  input  cce_msg_pkg::lce_id_t      req_lce_i,
  input  cce_msg_pkg::lce_id_t      owner_lce_i,
  input  logic                      owner_excl_i,
  input  cce_msg_pkg::paddr_t       inv_addr_i,
  output cce_msg_pkg::lce_id_t      sel_lce_o,
  output cce_msg_pkg::way_id_t      sel_way_o,
  output logic                      last_o,
  output cce_msg_pkg::paddr_t       addr_o
);

  cce_msg_pkg::sharers_t mask_r;
  cce_msg_pkg::sharer_ways_t ways_r;
  cce_msg_pkg::paddr_t addr_r;

  cce_msg_pkg::sharers_t req_oh;
  cce_msg_pkg::sharers_t owner_oh;
  cce_msg_pkg::sharers_t sel_oh;
  cce_msg_pkg::sharers_t load_mask;

  // one-hot of requester and, when flagged, owner
  assign req_oh = cce_msg_pkg::sharers_t'(1) << req_lce_i;
  assign owner_oh = owner_excl_i ? (cce_msg_pkg::sharers_t'(1) << owner_lce_i) : '0;
  assign load_mask = sharers_hits_i & ~req_oh & ~owner_oh;

  // lowest set bit wins, scan from the top so low ids overwrite
  always_comb begin
    sel_lce_o = '0;
    for (int i = cce_msg_pkg::num_lce - 1; i >= 0; i--) begin
      if (mask_r[i]) begin
        sel_lce_o = cce_msg_pkg::lce_id_t'(i);
      end
    end
  end

  assign sel_oh = cce_msg_pkg::sharers_t'(1) << sel_lce_o;
  assign sel_way_o = ways_r[sel_lce_o*cce_msg_pkg::way_width +: cce_msg_pkg::way_width];
  // nothing left once the pick is removed
  assign last_o = ((mask_r & ~sel_oh) == '0);
  assign addr_o = addr_r;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      mask_r <= '0;
    end else if (load_i) begin
      mask_r <= load_mask;
    end else if (step_i) begin
      mask_r <= mask_r & ~sel_oh;
    end
  end

  // ways and address are held for the whole sequence
  always_ff @(posedge clk_i) begin
    if (load_i) begin
      ways_r <= sharers_ways_i;
      addr_r <= inv_addr_i;
    end
  end

endmodule

//--- verilog/inv_ack_counter.sv
// Outstanding invalidation counter
`timescale 1ns/100ps

module inv_ack_counter (
  input  logic clk_i,
  input  logic reset_i,
  input  logic clr_i,
  input  logic inc_i,
  input  logic dec_i,
  output logic zero_o,
  output logic one_o
);

  cce_msg_pkg::inv_cnt_t cnt_r;

  always_ff @(posedge clk_i) begin
    if (reset_i || clr_i) begin
      cnt_r <= '0;
    end else if (inc_i && !dec_i) begin
      // saturate at one per LCE
      if (cnt_r != cce_msg_pkg::inv_cnt_max) begin
        cnt_r <= cnt_r + cce_msg_pkg::inv_cnt_t'(1);
      end
    end else if (dec_i && !inc_i) begin
      // stray ack never wraps below zero
      if (cnt_r != '0) begin
        cnt_r <= cnt_r - cce_msg_pkg::inv_cnt_t'(1);
      end
    end
  end

  assign zero_o = (cnt_r == '0);
  assign one_o = (cnt_r == cce_msg_pkg::inv_cnt_t'(1));

endmodule

//--- verilog/lce_cmd_mux.sv
// LCE command and directory write mux
`timescale 1ns/100ps

module lce_cmd_mux (
  input  logic                     inv_sel_i,
  input  cce_msg_pkg::lce_cmd_t    fwd_type_i,
  input  cce_msg_pkg::lce_id_t     fwd_dst_i,
  input  cce_msg_pkg::paddr_t      fwd_addr_i,
  input  cce_msg_pkg::way_id_t     fwd_way_i,
  input  cce_msg_pkg::coh_state_t  fwd_state_i,
  input  cce_msg_pkg::block_data_t fwd_data_i,
  input  cce_msg_pkg::lce_id_t     sel_lce_i,
  input  cce_msg_pkg::way_id_t     sel_way_i,
  input  cce_msg_pkg::paddr_t      inv_addr_i,
  input  logic                     pend_from_resp_i,
  input  cce_msg_pkg::paddr_t      lce_resp_addr_i,
  input  cce_msg_pkg::paddr_t      mem_resp_addr_i,
  output cce_msg_pkg::lce_cmd_t    lce_cmd_type_o,
  output cce_msg_pkg::lce_id_t     lce_cmd_dst_o,
  output cce_msg_pkg::lce_id_t     lce_cmd_src_o,
  output cce_msg_pkg::paddr_t      lce_cmd_addr_o,
  output cce_msg_pkg::way_id_t     lce_cmd_way_o,
  output cce_msg_pkg::coh_state_t  lce_cmd_state_o,
  output cce_msg_pkg::block_data_t lce_cmd_data_o,
  output cce_msg_pkg::paddr_t      dir_addr_o,
  output cce_msg_pkg::lce_id_t     dir_lce_o,
  output cce_msg_pkg::way_id_t     dir_way_o,
  output cce_msg_pkg::paddr_t      pending_w_addr_o
);

  // invalidate takes the picked sharer, forward takes the memory fields
  assign lce_cmd_type_o = inv_sel_i ? cce_msg_pkg::cmd_inv : fwd_type_i;
  assign lce_cmd_dst_o = inv_sel_i ? sel_lce_i : fwd_dst_i;
  assign lce_cmd_addr_o = inv_sel_i ? inv_addr_i : fwd_addr_i;
  assign lce_cmd_way_o = inv_sel_i ? sel_way_i : fwd_way_i;
  // invalidate has no state or data
  assign lce_cmd_state_o = inv_sel_i ? cce_msg_pkg::coh_i : fwd_state_i;
  assign lce_cmd_data_o = inv_sel_i ? '0 : fwd_data_i;
  assign lce_cmd_src_o = cce_msg_pkg::cce_id;

  // directory entry of the sharer being invalidated
  assign dir_addr_o = inv_addr_i;
  assign dir_lce_o = sel_lce_i;
  assign dir_way_o = sel_way_i;

  // memory response owns the pending port when it writes
  assign pending_w_addr_o = pend_from_resp_i ? mem_resp_addr_i : lce_resp_addr_i;

endmodule

//--- verilog/cce_msg_top.sv
// Coherence engine message unit
`timescale 1ns/100ps

module cce_msg_top (
  input  logic                      clk_i,
  input  logic                      reset_i,
  // memory response
  input  logic                      mem_resp_v_i,
  input  cce_msg_pkg::mem_msg_t     mem_resp_type_i,
  input  cce_msg_pkg::paddr_t       mem_resp_addr_i,
  input  cce_msg_pkg::lce_id_t      mem_resp_lce_i,
  input  cce_msg_pkg::way_id_t      mem_resp_way_i,
  input  cce_msg_pkg::coh_state_t   mem_resp_state_i,
  input  cce_msg_pkg::block_data_t  mem_resp_data_i,
  output logic                      mem_resp_yumi_o,
  // LCE response
  input  logic                      lce_resp_v_i,
  input  cce_msg_pkg::lce_resp_t    lce_resp_type_i,
  input  cce_msg_pkg::paddr_t       lce_resp_addr_i,
  output logic                      lce_resp_yumi_o,
  // invalidation start
  input  logic                      inv_start_i,
  input  cce_msg_pkg::paddr_t       inv_addr_i,
  input  cce_msg_pkg::sharers_t     sharers_hits_i,
  input  cce_msg_pkg::sharer_ways_t sharers_ways_i,
  input  cce_msg_pkg::lce_id_t      req_lce_i,
  input  cce_msg_pkg::lce_id_t      owner_lce_i,
  input  logic                      owner_excl_i,
  // LCE command
  input  logic                      lce_cmd_ready_i,
  output logic                      lce_cmd_v_o,
  output cce_msg_pkg::lce_cmd_t     lce_cmd_type_o,
  output cce_msg_pkg::lce_id_t      lce_cmd_dst_o,
  output cce_msg_pkg::lce_id_t      lce_cmd_src_o,
  output cce_msg_pkg::paddr_t       lce_cmd_addr_o,
  output cce_msg_pkg::way_id_t      lce_cmd_way_o,
  output cce_msg_pkg::coh_state_t   lce_cmd_state_o,
  output cce_msg_pkg::block_data_t  lce_cmd_data_o,
  // pending and directory writes
  output logic                      pending_w_v_o,
  output cce_msg_pkg::paddr_t       pending_w_addr_o,
  output logic                      dir_w_v_o,
  output cce_msg_pkg::paddr_t       dir_addr_o,
  output cce_msg_pkg::lce_id_t      dir_lce_o,
  output cce_msg_pkg::way_id_t      dir_way_o,
  output logic                      busy_o
);

  logic fwd_cmd_v, fwd_pend_v;
  cce_msg_pkg::lce_cmd_t fwd_type;
  cce_msg_pkg::lce_id_t fwd_dst;
  cce_msg_pkg::paddr_t fwd_addr;
  cce_msg_pkg::way_id_t fwd_way;
  cce_msg_pkg::coh_state_t fwd_state;
  cce_msg_pkg::block_data_t fwd_data;
  logic inv_sel, pend_from_resp;
  logic load, step, cnt_clr, cnt_inc, cnt_dec;
  cce_msg_pkg::lce_id_t sel_lce;
  cce_msg_pkg::way_id_t sel_way;
  cce_msg_pkg::paddr_t inv_addr;
  logic last, cnt_zero, cnt_one;

  mem_resp_fwd mem_resp_fwd_inst (
    .mem_resp_v_i, .mem_resp_type_i, .mem_resp_addr_i, .mem_resp_lce_i,
    .mem_resp_way_i, .mem_resp_state_i, .mem_resp_data_i,
    .fwd_cmd_v_o(fwd_cmd_v), .fwd_pend_v_o(fwd_pend_v), .fwd_type_o(fwd_type),
    .fwd_dst_o(fwd_dst), .fwd_addr_o(fwd_addr), .fwd_way_o(fwd_way),
    .fwd_state_o(fwd_state), .fwd_data_o(fwd_data)
  );

  cce_msg_ctrl cce_msg_ctrl_inst (
    .clk_i, .reset_i, .inv_start_i, .fwd_cmd_v_i(fwd_cmd_v), .fwd_pend_v_i(fwd_pend_v),
    .mem_resp_v_i, .lce_resp_v_i, .lce_resp_type_i, .lce_cmd_ready_i,
    .last_i(last), .cnt_zero_i(cnt_zero), .cnt_one_i(cnt_one),
    .mem_resp_yumi_o, .lce_resp_yumi_o, .lce_cmd_v_o, .inv_sel_o(inv_sel),
    .pending_w_v_o, .pend_from_resp_o(pend_from_resp), .dir_w_v_o,
    .load_o(load), .step_o(step), .cnt_clr_o(cnt_clr), .cnt_inc_o(cnt_inc),
    .cnt_dec_o(cnt_dec), .busy_o
  );

  inv_sharer_select inv_sharer_select_inst (
    .clk_i, .reset_i, .load_i(load), .step_i(step), .sharers_hits_i, .sharers_ways_i,
    .req_lce_i, .owner_lce_i, .owner_excl_i, .inv_addr_i,
    .sel_lce_o(sel_lce), .sel_way_o(sel_way), .last_o(last), .addr_o(inv_addr)
  );

  inv_ack_counter inv_ack_counter_inst (
    .clk_i, .reset_i, .clr_i(cnt_clr), .inc_i(cnt_inc), .dec_i(cnt_dec),
    .zero_o(cnt_zero), .one_o(cnt_one)
  );

  lce_cmd_mux lce_cmd_mux_inst (
    .inv_sel_i(inv_sel), .fwd_type_i(fwd_type), .fwd_dst_i(fwd_dst),
    .fwd_addr_i(fwd_addr), .fwd_way_i(fwd_way), .fwd_state_i(fwd_state),
    .fwd_data_i(fwd_data), .sel_lce_i(sel_lce), .sel_way_i(sel_way),
    .inv_addr_i(inv_addr), .pend_from_resp_i(pend_from_resp), .lce_resp_addr_i,
    .mem_resp_addr_i, .lce_cmd_type_o, .lce_cmd_dst_o, .lce_cmd_src_o, .lce_cmd_addr_o,
    .lce_cmd_way_o, .lce_cmd_state_o, .lce_cmd_data_o, .dir_addr_o, .dir_lce_o,
    .dir_way_o, .pending_w_addr_o
  );

endmodule

//--- testbench/cce_msg_chk.sv
// Message unit port assertions
`timescale 1ns/100ps

module cce_msg_chk (
  input logic                  clk_i,
  input logic                  reset_i,
  input logic                  lce_cmd_ready_i,
  input logic                  lce_cmd_v_o,
  input cce_msg_pkg::lce_cmd_t lce_cmd_type_o,
  input logic                  dir_w_v_o,
  input logic                  mem_resp_yumi_o,
  input logic                  lce_resp_yumi_o,
  input logic                  pending_w_v_o,
  input logic                  busy_o
);

  // command only offered while the LCE side is ready
  cmd_needs_ready: assert property (
    @(posedge clk_i) disable iff (reset_i) lce_cmd_v_o |-> lce_cmd_ready_i
  ) else $error("LCE command valid while ready is low");

  // every directory write rides on an invalidate
  dir_with_inv: assert property (
    @(posedge clk_i) disable iff (reset_i)
    dir_w_v_o |-> (lce_cmd_v_o && lce_cmd_type_o == cce_msg_pkg::cmd_inv)
  ) else $error("directory write without an invalidate command");

  // state is known one clock into reset, all outputs quiet from then on
  quiet_in_reset: assert property (
    @(posedge clk_i) (reset_i && $past(reset_i)) |->
    !(lce_cmd_v_o || dir_w_v_o || mem_resp_yumi_o || lce_resp_yumi_o
      || pending_w_v_o || busy_o)
  ) else $error("output active during reset");

endmodule

//--- testbench/cce_msg_tb.sv
// Message unit testbench
`timescale 1ns/100ps

module cce_msg_tb;

  localparam int clk_period = 100;
  localparam int reset_cycles = 8;

  // one clock of stimulus and the outputs expected in it
  typedef struct packed {
    logic ready, mem_v, lce_v, inv_start;
    cce_msg_pkg::mem_msg_t mem_type;
    cce_msg_pkg::paddr_t mem_addr, lce_addr;
    cce_msg_pkg::lce_id_t mem_lce;
    cce_msg_pkg::way_id_t mem_way;
    cce_msg_pkg::coh_state_t mem_state;
    cce_msg_pkg::block_data_t mem_data;
    cce_msg_pkg::lce_resp_t lce_type;
    logic exp_mem_yumi, exp_lce_yumi, exp_cmd_v, exp_pend_v, exp_dir_v, exp_busy;
    cce_msg_pkg::lce_cmd_t exp_cmd_type;
    cce_msg_pkg::lce_id_t exp_cmd_dst;
    cce_msg_pkg::paddr_t exp_cmd_addr, exp_pend_addr;
    cce_msg_pkg::way_id_t exp_cmd_way;
    cce_msg_pkg::coh_state_t exp_cmd_state;
    cce_msg_pkg::block_data_t exp_cmd_data;
  } row_t;

  logic clk_i, reset_i;
  logic mem_resp_v_i, lce_resp_v_i, inv_start_i, owner_excl_i, lce_cmd_ready_i;
  cce_msg_pkg::mem_msg_t mem_resp_type_i;
  cce_msg_pkg::paddr_t mem_resp_addr_i, lce_resp_addr_i, inv_addr_i;
  cce_msg_pkg::lce_id_t mem_resp_lce_i, req_lce_i, owner_lce_i;
  cce_msg_pkg::way_id_t mem_resp_way_i;
  cce_msg_pkg::coh_state_t mem_resp_state_i;
  cce_msg_pkg::block_data_t mem_resp_data_i;
  cce_msg_pkg::lce_resp_t lce_resp_type_i;
  cce_msg_pkg::sharers_t sharers_hits_i;
  cce_msg_pkg::sharer_ways_t sharers_ways_i;
  logic mem_resp_yumi_o, lce_resp_yumi_o, lce_cmd_v_o, pending_w_v_o, dir_w_v_o, busy_o;
  cce_msg_pkg::lce_cmd_t lce_cmd_type_o;
  cce_msg_pkg::lce_id_t lce_cmd_dst_o, lce_cmd_src_o, dir_lce_o;
  cce_msg_pkg::paddr_t lce_cmd_addr_o, pending_w_addr_o, dir_addr_o;
  cce_msg_pkg::way_id_t lce_cmd_way_o, dir_way_o;
  cce_msg_pkg::coh_state_t lce_cmd_state_o;
  cce_msg_pkg::block_data_t lce_cmd_data_o;

  row_t rows[$];
  int errors = 0;
  int checks = 0;
  int cur_row = 0;
  logic table_ready = 1'b0;
  logic [31:0] lfsr_state = 32'h7f3;

  cce_msg_top cce_msg_top_inst (.*);

  bind cce_msg_top cce_msg_chk cce_msg_chk_inst (
    .clk_i, .reset_i, .lce_cmd_ready_i, .lce_cmd_v_o, .lce_cmd_type_o, .dir_w_v_o,
    .mem_resp_yumi_o, .lce_resp_yumi_o, .pending_w_v_o, .busy_o
  );

  initial begin
    clk_i = 1'b0;
    forever #(clk_period / 2) clk_i = ~clk_i;
  end

  // Galois form with taps of x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  // one LFSR step per bit
  function automatic logic [63:0] take_bits(int n);
    logic [63:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[62:0], lfsr_state[0]};
      lfsr_state = lfsr_next(lfsr_state);
    end
    return v;
  endfunction

  // nothing driven and nothing expected with the LCE side ready
  function automatic row_t idle_row();
    row_t r;
    r = '0;
    r.ready = 1'b1;
    return r;
  endfunction

  // expected reaction to the memory and LCE responses of a row outside invalidation
  function automatic row_t fill_expect(row_t r);
    logic mem_take;
    logic mem_pend;
    // writeback never waits for ready, the rest do
    mem_take = r.mem_v && (r.mem_type == cce_msg_pkg::mem_wr || r.ready);
    mem_pend = mem_take && (r.mem_type == cce_msg_pkg::mem_rd
                            || r.mem_type == cce_msg_pkg::mem_wr);
    r.exp_mem_yumi = mem_take;
    r.exp_cmd_v = mem_take && (r.mem_type != cce_msg_pkg::mem_wr);
    r.exp_cmd_dst = r.mem_lce;
    r.exp_cmd_addr = r.mem_addr;
    r.exp_cmd_way = r.mem_way;
    r.exp_cmd_state = r.mem_state;
    r.exp_cmd_data = r.mem_data;
    case (r.mem_type)
      cce_msg_pkg::mem_uc_rd: r.exp_cmd_type = cce_msg_pkg::cmd_uc_data;
      cce_msg_pkg::mem_uc_wr: begin
        // store done goes out empty
        r.exp_cmd_type = cce_msg_pkg::cmd_uc_st_done;
        r.exp_cmd_state = cce_msg_pkg::coh_i;
        r.exp_cmd_data = '0;
      end
      default: r.exp_cmd_type = cce_msg_pkg::cmd_data;
    endcase
    r.exp_pend_v = mem_pend;
    r.exp_pend_addr = r.mem_addr;
    // coh ack gets the pending port only when memory leaves it free
    r.exp_lce_yumi = r.lce_v && (r.lce_type == cce_msg_pkg::resp_coh_ack) && !mem_pend;
    if (r.exp_lce_yumi) begin
      r.exp_pend_v = 1'b1;
      r.exp_pend_addr = r.lce_addr;
    end
    return r;
  endfunction

  // memory response with fresh random fields
  function automatic row_t mem_row(cce_msg_pkg::mem_msg_t t, logic rdy);
    row_t r;
    r = idle_row();
    r.ready = rdy;
    r.mem_v = 1'b1;
    r.mem_type = t;
    r.mem_addr = cce_msg_pkg::paddr_t'(take_bits(cce_msg_pkg::paddr_width));
    r.mem_lce = cce_msg_pkg::lce_id_t'(take_bits(cce_msg_pkg::lce_id_width));
    r.mem_way = cce_msg_pkg::way_id_t'(take_bits(cce_msg_pkg::way_width));
    r.mem_state = cce_msg_pkg::coh_state_t'(take_bits(cce_msg_pkg::coh_state_width));
    r.mem_data = take_bits(cce_msg_pkg::block_width);
    return fill_expect(r);
  endfunction

  function automatic row_t ack_row(cce_msg_pkg::lce_resp_t t, cce_msg_pkg::paddr_t addr);
    row_t r;
    r = idle_row();
    r.lce_v = 1'b1;
    r.lce_type = t;
    r.lce_addr = addr;
    return fill_expect(r);
  endfunction

  // invalidate to one sharer plus its directory write
  function automatic row_t inv_cmd_row(cce_msg_pkg::lce_id_t dst);
    row_t r;
    r = idle_row();
    r.exp_cmd_v = 1'b1;
    r.exp_cmd_type = cce_msg_pkg::cmd_inv;
    r.exp_cmd_dst = dst;
    r.exp_cmd_addr = inv_addr_i;
    // ways packed with LCE 0 lowest
    r.exp_cmd_way = sharers_ways_i[dst*cce_msg_pkg::way_width +: cce_msg_pkg::way_width];
    r.exp_cmd_state = cce_msg_pkg::coh_i;
    r.exp_cmd_data = '0;
    r.exp_dir_v = 1'b1;
    r.exp_busy = 1'b1;
    return r;
  endfunction

  task automatic compare(string what, logic [63:0] got, logic [63:0] want);
    checks++;
    if (got !== want) begin
      errors++;
      $display("[FAIL] %0t row %0d %s: got %0h, expected %0h", $time, cur_row, what, got, want);
    end
  endtask

  task automatic apply_row(row_t r);
    lce_cmd_ready_i = r.ready;
    mem_resp_v_i = r.mem_v;
    mem_resp_type_i = r.mem_type;
    mem_resp_addr_i = r.mem_addr;
    mem_resp_lce_i = r.mem_lce;
    mem_resp_way_i = r.mem_way;
    mem_resp_state_i = r.mem_state;
    mem_resp_data_i = r.mem_data;
    lce_resp_v_i = r.lce_v;
    lce_resp_type_i = r.lce_type;
    lce_resp_addr_i = r.lce_addr;
    inv_start_i = r.inv_start;
  endtask

  task automatic check_row(row_t r);
    compare("mem_resp_yumi", 64'(mem_resp_yumi_o), 64'(r.exp_mem_yumi));
    compare("lce_resp_yumi", 64'(lce_resp_yumi_o), 64'(r.exp_lce_yumi));
    compare("lce_cmd_v", 64'(lce_cmd_v_o), 64'(r.exp_cmd_v));
    if (r.exp_cmd_v) begin
      compare("cmd type", 64'(lce_cmd_type_o), 64'(r.exp_cmd_type));
      compare("cmd dst", 64'(lce_cmd_dst_o), 64'(r.exp_cmd_dst));
      compare("cmd src", 64'(lce_cmd_src_o), 64'(cce_msg_pkg::cce_id));
      compare("cmd addr", 64'(lce_cmd_addr_o), 64'(r.exp_cmd_addr));
      compare("cmd way", 64'(lce_cmd_way_o), 64'(r.exp_cmd_way));
      compare("cmd state", 64'(lce_cmd_state_o), 64'(r.exp_cmd_state));
      compare("cmd data", 64'(lce_cmd_data_o), 64'(r.exp_cmd_data));
    end
    compare("pending_w_v", 64'(pending_w_v_o), 64'(r.exp_pend_v));
    if (r.exp_pend_v) begin
      compare("pending addr", 64'(pending_w_addr_o), 64'(r.exp_pend_addr));
    end
    compare("dir_w_v", 64'(dir_w_v_o), 64'(r.exp_dir_v));
    // directory entry matches the invalidate on the command port
    if (r.exp_dir_v) begin
      compare("dir addr", 64'(dir_addr_o), 64'(r.exp_cmd_addr));
      compare("dir lce", 64'(dir_lce_o), 64'(r.exp_cmd_dst));
      compare("dir way", 64'(dir_way_o), 64'(r.exp_cmd_way));
    end
    compare("busy", 64'(busy_o), 64'(r.exp_busy));
  endtask

  task automatic build_table();
    row_t r;
    cce_msg_pkg::paddr_t ack_addr;
    // writeback held through reset is left alone while still in st_reset
    r = idle_row();
    r.mem_v = 1'b1;
    r.mem_type = cce_msg_pkg::mem_wr;
    r.mem_addr = cce_msg_pkg::paddr_t'(take_bits(cce_msg_pkg::paddr_width));
    rows.push_back(r);
    // taken on the first clock in st_ready
    rows.push_back(fill_expect(r));
    rows.push_back(mem_row(cce_msg_pkg::mem_rd, 1'b1));
    rows.push_back(mem_row(cce_msg_pkg::mem_uc_rd, 1'b1));
    rows.push_back(mem_row(cce_msg_pkg::mem_uc_wr, 1'b1));
    // writeback taken with the LCE side stalled
    rows.push_back(mem_row(cce_msg_pkg::mem_wr, 1'b0));
    ack_addr = cce_msg_pkg::paddr_t'(take_bits(cce_msg_pkg::paddr_width));
    rows.push_back(ack_row(cce_msg_pkg::resp_coh_ack, ack_addr));
    // coh ack against a fill where the fill takes the pending port first
    ack_addr = cce_msg_pkg::paddr_t'(take_bits(cce_msg_pkg::paddr_width));
    r = mem_row(cce_msg_pkg::mem_rd, 1'b1);
    r.lce_v = 1'b1;
    r.lce_type = cce_msg_pkg::resp_coh_ack;
    r.lce_addr = ack_addr;
    rows.push_back(fill_expect(r));
    rows.push_back(ack_row(cce_msg_pkg::resp_coh_ack, ack_addr));
    // stalled fill holds, then goes out
    r = mem_row(cce_msg_pkg::mem_rd, 1'b0);
    rows.push_back(r);
    r.ready = 1'b1;
    rows.push_back(fill_expect(r));
    // invalidate LCEs 1 and 3, requester 0 and owner 2 are skipped
    r = idle_row();
    r.inv_start = 1'b1;
    rows.push_back(r);
    r = idle_row();
    r.ready = 1'b0;
    r.exp_busy = 1'b1;
    rows.push_back(r);
    // forward wins the command port over the invalidate
    r = mem_row(cce_msg_pkg::mem_uc_rd, 1'b1);
    r.exp_busy = 1'b1;
    rows.push_back(r);
    rows.push_back(inv_cmd_row(2'd1));
    rows.push_back(inv_cmd_row(2'd3));
    r = idle_row();
    r.exp_busy = 1'b1;
    rows.push_back(r);
    // two inv acks drain the count
    r = ack_row(cce_msg_pkg::resp_inv_ack, inv_addr_i);
    r.exp_lce_yumi = 1'b1;
    r.exp_busy = 1'b1;
    rows.push_back(r);
    rows.push_back(r);
    rows.push_back(idle_row());
    // stray inv ack outside invalidation is left waiting
    rows.push_back(ack_row(cce_msg_pkg::resp_inv_ack, inv_addr_i));
    rows.push_back(idle_row());
  endtask

  initial begin
    reset_i = 1'b1;
    sharers_hits_i = 4'b1111;
    req_lce_i = 2'd0;
    owner_lce_i = 2'd2;
    owner_excl_i = 1'b1;
    inv_addr_i = cce_msg_pkg::paddr_t'(take_bits(cce_msg_pkg::paddr_width));
    sharers_ways_i = cce_msg_pkg::sharer_ways_t'(take_bits(cce_msg_pkg::num_lce
                                                           * cce_msg_pkg::way_width));
    build_table();
    // first row already sits on the inputs during reset
    apply_row(rows[0]);
    table_ready = 1'b1;
    repeat (reset_cycles) @(negedge clk_i);
    reset_i = 1'b0;
    // drive at the falling edge, sample a quarter period later
    foreach (rows[i]) begin
      cur_row = i;
      apply_row(rows[i]);
      #(clk_period / 4);
      check_row(rows[i]);
      @(negedge clk_i);
    end
    while (busy_o) begin
      @(negedge clk_i);
    end
    $display("checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

  // one clock per row plus reset and a margin for the final drain
  initial begin
    wait (table_ready);
    #((reset_cycles + rows.size() + 16) * clk_period);
    $display("timeout: the run did not finish within the expected number of cycles");
    $display("Done: errors found");
    $finish;
  end

endmodule

//--- project.f
verilog/cce_msg_pkg.sv
verilog/mem_resp_fwd.sv
verilog/cce_msg_ctrl.sv
verilog/inv_sharer_select.sv
verilog/inv_ack_counter.sv
verilog/lce_cmd_mux.sv
verilog/cce_msg_top.sv
testbench/cce_msg_chk.sv
testbench/cce_msg_tb.sv

//--- Makefile
TOP = cce_msg_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -Wall -f project.f --top-module cce_msg_top

sim:
	verilator --binary --timing --assert -f project.f --top-module $(TOP)
	out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -qx 'Done: no errors'

clean:
	rm -rf obj_dir
